// ==== src.f ====
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/status_reg.sv
rtl/pc.sv
rtl/idec.sv
rtl/sequencer.sv
rtl/cpu.sv
verification/tb_clock.sv
verification/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module cpu_tb -f src.f -o cpu_tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed"
	exit $status
fi

./obj_dir/cpu_tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed"
	exit $status
fi
exit 0

// ==== verification/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

	localparam int CLK_PERIOD_NS = 10;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_PROGRAMS = 4;
	localparam int NUM_INSTR = 60;
	localparam int STALL_FACTOR = 2;
	localparam int RUN_CYCLES = RESET_CYCLES + (NUM_INSTR + 1) * 6 * STALL_FACTOR + 50;
	localparam int WATCHDOG_NS = NUM_PROGRAMS * 2 * RUN_CYCLES * CLK_PERIOD_NS;

	logic clk;
	logic reset;
	logic rdy;
	logic [15:0] addr;
	logic [7:0] rd_data;
	logic [7:0] wr_data;
	logic we;
	logic fetch;

	logic [7:0] mem [0:65535];
	logic wr_pend = 1'b0;
	logic [15:0] wr_addr_q;
	logic [7:0] wr_data_q;

	// Expected bus activity from the reference model
	logic [15:0] exp_fetch[$];
	logic [15:0] exp_wr_addr[$];
	logic [7:0] exp_wr_data[$];
	logic [15:0] loop_addr;

	int fetch_idx;
	int wr_idx;
	logic checking;
	logic run_done;

	tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) u_clock (.clk_o(clk));

	cpu u_cpu (
		.clk_i(clk), .reset_i(reset), .rdy_i(rdy), .addr_o(addr),
		.data_i(rd_data), .data_o(wr_data), .we_o(we), .fetch_o(fetch));

	assign rd_data = mem[addr];

	// Write completes on the rising edge, memory updated half a cycle later
	always @(posedge clk) begin
		wr_pend <= !reset && rdy && we;
		wr_addr_q <= addr;
		wr_data_q <= wr_data;
	end

	always @(negedge clk) begin
		if (wr_pend) begin
			mem[wr_addr_q] = wr_data_q;
		end
	end

	task automatic abort_run();
		$display("Test failures found");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_addr(input string name, input logic [15:0] got,
			input logic [15:0] expected);
		if (got !== expected) begin
			$display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, expected);
			abort_run();
		end
	endtask

	task automatic check_data(input string name, input logic [7:0] got,
			input logic [7:0] expected);
		if (got !== expected) begin
			$display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, expected);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, expected);
			abort_run();
		end
	endtask

	function automatic int instr_length(input logic [7:0] op);
		case (op)
			cpu_pkg::OP_LDA_IMM, cpu_pkg::OP_LDX_IMM, cpu_pkg::OP_ADC_IMM,
			cpu_pkg::OP_AND_IMM, cpu_pkg::OP_EOR_IMM, cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE:
				return 2;
			cpu_pkg::OP_STA_ABS, cpu_pkg::OP_JMP_ABS:
				return 3;
			default:
				return 1;
		endcase
	endfunction

	// Forward-only branches and jumps, so every program reaches its final loop
	task automatic build_program();
		logic [7:0] ops [0:NUM_INSTR];
		logic [15:0] at [0:NUM_INSTR];
		logic [15:0] a;
		int i;
		int j;
		a = cpu_pkg::RESET_PC;
		for (i = 0; i < NUM_INSTR; i++) begin
			case ($urandom_range(17, 0))
				0: ops[i] = cpu_pkg::OP_LDA_IMM;
				1: ops[i] = cpu_pkg::OP_LDX_IMM;
				2, 3: ops[i] = cpu_pkg::OP_ADC_IMM;
				4: ops[i] = cpu_pkg::OP_AND_IMM;
				5: ops[i] = cpu_pkg::OP_EOR_IMM;
				6, 7: ops[i] = cpu_pkg::OP_STA_ABS;
				8: ops[i] = cpu_pkg::OP_INX;
				9: ops[i] = cpu_pkg::OP_TAX;
				10: ops[i] = cpu_pkg::OP_CLC;
				11: ops[i] = cpu_pkg::OP_SEC;
				12: ops[i] = cpu_pkg::OP_BEQ;
				13: ops[i] = cpu_pkg::OP_BNE;
				14: ops[i] = cpu_pkg::OP_JMP_ABS;
				15: ops[i] = 8'h02;
				16: ops[i] = 8'hFF;
				default: ops[i] = cpu_pkg::OP_NOP;
			endcase
			at[i] = a;
			a = a + 16'(instr_length(ops[i]));
		end
		at[NUM_INSTR] = a;
		for (i = 0; i < NUM_INSTR; i++) begin
			mem[at[i]] = ops[i];
			j = i + 1 + int'($urandom_range(3, 0));
			if (j > NUM_INSTR) begin
				j = NUM_INSTR;
			end
			case (ops[i])
				cpu_pkg::OP_STA_ABS: begin
					mem[at[i] + 16'd1] = 8'($urandom);
					mem[at[i] + 16'd2] = 8'h03;
				end
				cpu_pkg::OP_JMP_ABS: begin
					mem[at[i] + 16'd1] = at[j][7:0];
					mem[at[i] + 16'd2] = at[j][15:8];
				end
				cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE: begin
					mem[at[i] + 16'd1] = 8'(at[j] - at[i] - 16'd2);
				end
				default: begin
					// Zero operands often, to exercise Z
					mem[at[i] + 16'd1] = ($urandom_range(3, 0) == 0) ? 8'h00 : 8'($urandom);
				end
			endcase
		end
		mem[a] = cpu_pkg::OP_JMP_ABS;
		mem[a + 16'd1] = a[7:0];
		mem[a + 16'd2] = a[15:8];
	endtask

	// Instruction-level model of the subset
	function automatic void run_reference();
		logic [15:0] rpc;
		logic [15:0] target;
		logic [7:0] a;
		logic [7:0] x;
		logic [7:0] opc;
		logic [7:0] opnd;
		logic [8:0] sum;
		logic c;
		logic z;
		bit at_end;
		exp_fetch.delete();
		exp_wr_addr.delete();
		exp_wr_data.delete();
		rpc = cpu_pkg::RESET_PC;
		a = 8'h00;
		x = 8'h00;
		c = cpu_pkg::STATUS_RESET[0];
		z = cpu_pkg::STATUS_RESET[1];
		at_end = 1'b0;
		while (!at_end) begin
			exp_fetch.push_back(rpc);
			opc = mem[rpc];
			opnd = mem[rpc + 16'd1];
			target = {mem[rpc + 16'd2], opnd};
			case (opc)
				cpu_pkg::OP_LDA_IMM: begin
					a = opnd;
					z = (a == 8'h00);
				end
				cpu_pkg::OP_LDX_IMM: begin
					x = opnd;
					z = (x == 8'h00);
				end
				cpu_pkg::OP_ADC_IMM: begin
					sum = {1'b0, a} + {1'b0, opnd} + {8'h00, c};
					a = sum[7:0];
					c = sum[8];
					z = (a == 8'h00);
				end
				cpu_pkg::OP_AND_IMM: begin
					a = a & opnd;
					z = (a == 8'h00);
				end
				cpu_pkg::OP_EOR_IMM: begin
					a = a ^ opnd;
					z = (a == 8'h00);
				end
				cpu_pkg::OP_STA_ABS: begin
					exp_wr_addr.push_back(target);
					exp_wr_data.push_back(a);
				end
				cpu_pkg::OP_INX: begin
					x = x + 8'd1;
					z = (x == 8'h00);
				end
				cpu_pkg::OP_TAX: begin
					x = a;
					z = (x == 8'h00);
				end
				cpu_pkg::OP_CLC: c = 1'b0;
				cpu_pkg::OP_SEC: c = 1'b1;
				default: begin
				end
			endcase
			if (opc == cpu_pkg::OP_JMP_ABS) begin
				at_end = (target == rpc);
				rpc = target;
			end else if ((opc == cpu_pkg::OP_BEQ && z) || (opc == cpu_pkg::OP_BNE && !z)) begin
				rpc = rpc + 16'd2 + {{8{opnd[7]}}, opnd};
			end else begin
				rpc = rpc + 16'(instr_length(opc));
			end
		end
		loop_addr = exp_fetch[exp_fetch.size() - 1];
	endfunction

	task automatic execute_program(input int prog_num, input bit stall_en);
		reset = 1'b1;
		rdy = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		fetch_idx = 0;
		wr_idx = 0;
		run_done = 1'b0;
		checking = 1'b1;
		reset = 1'b0;
		while (!run_done) begin
			@(negedge clk);
			if (stall_en) begin
				rdy = ($urandom_range(99, 0) >= 30);
			end else begin
				rdy = 1'b1;
			end
		end
		$display("Program %0d, stalls %0d: %0d fetches, %0d writes, loop at %h",
			prog_num, stall_en, fetch_idx, wr_idx, loop_addr);
	endtask

	// Compare on completed bus cycles only
	always @(posedge clk) begin
		if (checking && rdy) begin
			if (fetch) begin
				check_flag("we_o", we, 1'b0);
				check_addr("addr_o (fetch)", addr, exp_fetch[fetch_idx]);
				fetch_idx = fetch_idx + 1;
				if (fetch_idx == exp_fetch.size()) begin
					if (wr_idx != exp_wr_addr.size()) begin
						$display("Error at %0t: final loop reached after %0d of %0d writes",
							$time, wr_idx, exp_wr_addr.size());
						abort_run();
					end else begin
						checking = 1'b0;
						run_done = 1'b1;
					end
				end
			end else if (we) begin
				if (wr_idx >= exp_wr_addr.size()) begin
					$display("Error at %0t: write to %h when no write was expected", $time, addr);
					abort_run();
				end else begin
					check_addr("addr_o (write)", addr, exp_wr_addr[wr_idx]);
					check_data("data_o", wr_data, exp_wr_data[wr_idx]);
					wr_idx = wr_idx + 1;
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns: program never reached its final loop", WATCHDOG_NS);
		abort_run();
	end

	initial begin
		int i;
		int p;
		void'($urandom(32'h89b6));
		reset = 1'b1;
		rdy = 1'b1;
		checking = 1'b0;
		run_done = 1'b0;
		fetch_idx = 0;
		wr_idx = 0;
		for (i = 0; i < 65536; i++) begin
			mem[i] = i[15:8] ^ i[7:0] ^ 8'hA5;
		end
		for (p = 0; p < NUM_PROGRAMS; p++) begin
			@(negedge clk);
			reset = 1'b1;
			build_program();
			run_reference();
			// Same program, with and without wait states
			execute_program(p, 1'b0);
			execute_program(p, 1'b1);
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 10
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD_NS / 2);
			clk_o = ~clk_o;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu (
	input  logic        clk_i,
	input  logic        reset_i,
	input  logic        rdy_i,
	output logic [15:0] addr_o,
	input  logic [7:0]  data_i,
	output logic [7:0]  data_o,
	output logic        we_o,
	output logic        fetch_o
);

	logic [7:0] ir;
	logic [7:0] acc;
	logic [7:0] x;
	logic [7:0] dl;
	logic [7:0] adl;
	logic [7:0] adh;

	cpu_pkg::op_kind_e kind;
	cpu_pkg::mode_e mode;
	cpu_pkg::alu_func_e alu_func;
	logic [7:0] flag_mask;
	logic use_x;

	logic ir_we, dl_we, adl_we, adh_we, acc_we, x_we;
	logic status_update, set_carry, clr_carry;
	logic pc_inc, pc_load, pc_branch, addr_sel;
	logic branch_cond;

	logic [7:0] alu_a, alu_b, alu_result;
	logic alu_carry, alu_zero, alu_sign, alu_ovf;
	logic [7:0] status;
	logic [15:0] pc_value;

	// Registers that steer control reset to a known state
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			ir <= cpu_pkg::OP_NOP;
			acc <= 8'h00;
			x <= 8'h00;
		end else begin
			if (ir_we) begin
				ir <= data_i;
			end
			if (acc_we) begin
				acc <= alu_result;
			end
			if (x_we) begin
				x <= alu_result;
			end
		end
	end

	// Data and address latches
	always_ff @(posedge clk_i) begin
		if (dl_we) begin
			dl <= data_i;
		end
		if (adl_we) begin
			adl <= data_i;
		end
		if (adh_we) begin
			adh <= data_i;
		end
	end

	assign alu_a = use_x ? x : acc;
	assign alu_b = (mode == cpu_pkg::MODE_IMPLIED) ? 8'h00 : dl;

	// Branch condition met, polarity from decoder
	assign branch_cond = status[cpu_pkg::STATUS_Z] ~^ use_x;

	assign addr_o = addr_sel ? {adh, adl} : pc_value;
	assign data_o = acc;

	idec u_idec (
		.opcode_i(ir), .kind_o(kind), .mode_o(mode), .alu_func_o(alu_func),
		.flag_mask_o(flag_mask), .use_x_o(use_x));

	alu u_alu (
		.alu_func_i(alu_func), .a_i(alu_a), .b_i(alu_b),
		.carry_i(status[cpu_pkg::STATUS_C]), .result_o(alu_result),
		.carry_o(alu_carry), .zero_o(alu_zero), .sign_o(alu_sign), .overflow_o(alu_ovf));

	status_reg u_status (
		.clk_i(clk_i), .reset_i(reset_i), .update_i(status_update),
		.flag_mask_i(flag_mask), .carry_i(alu_carry), .zero_i(alu_zero),
		.sign_i(alu_sign), .overflow_i(alu_ovf), .set_carry_i(set_carry),
		.clr_carry_i(clr_carry), .status_o(status));

	pc u_pc (
		.clk_i(clk_i), .reset_i(reset_i), .inc_i(pc_inc), .load_i(pc_load),
		.branch_i(pc_branch), .target_i({data_i, adl}), .offset_i(dl), .pc_o(pc_value));

	sequencer u_seq (
		.clk_i(clk_i), .reset_i(reset_i), .rdy_i(rdy_i), .kind_i(kind), .mode_i(mode),
		.zero_flag_i(branch_cond), .state_o(), .ir_we_o(ir_we), .dl_we_o(dl_we),
		.adl_we_o(adl_we), .adh_we_o(adh_we), .acc_we_o(acc_we), .x_we_o(x_we),
		.status_update_o(status_update), .set_carry_o(set_carry), .clr_carry_o(clr_carry),
		.pc_inc_o(pc_inc), .pc_load_o(pc_load), .pc_branch_o(pc_branch),
		.addr_sel_o(addr_sel), .we_o(we_o), .fetch_o(fetch_o));

endmodule

`default_nettype wire

// ==== rtl/sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sequencer (
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic                  rdy_i,
	input  cpu_pkg::op_kind_e     kind_i,
	input  cpu_pkg::mode_e        mode_i,
	input  logic                  zero_flag_i,
	output cpu_pkg::seq_state_e   state_o,
	output logic                  ir_we_o,
	output logic                  dl_we_o,
	output logic                  adl_we_o,
	output logic                  adh_we_o,
	output logic                  acc_we_o,
	output logic                  x_we_o,
	output logic                  status_update_o,
	output logic                  set_carry_o,
	output logic                  clr_carry_o,
	output logic                  pc_inc_o,
	output logic                  pc_load_o,
	output logic                  pc_branch_o,
	output logic                  addr_sel_o,
	output logic                  we_o,
	output logic                  fetch_o
);

	cpu_pkg::seq_state_e state_d;

	always_comb begin
		state_d = state_o;
		ir_we_o = 1'b0;
		dl_we_o = 1'b0;
		adl_we_o = 1'b0;
		adh_we_o = 1'b0;
		acc_we_o = 1'b0;
		x_we_o = 1'b0;
		status_update_o = 1'b0;
		set_carry_o = 1'b0;
		clr_carry_o = 1'b0;
		pc_inc_o = 1'b0;
		pc_load_o = 1'b0;
		pc_branch_o = 1'b0;
		// Bus strobes follow the state so they hold during a stall
		fetch_o = (state_o == cpu_pkg::ST_FETCH);
		we_o = (state_o == cpu_pkg::ST_WRITE);
		addr_sel_o = (state_o == cpu_pkg::ST_WRITE);
		case (state_o)
			cpu_pkg::ST_FETCH: begin
				ir_we_o = rdy_i;
				pc_inc_o = rdy_i;
				state_d = cpu_pkg::ST_OPERAND_LO;
				// Decoder still sees the previous instruction, finish it here
				case (kind_i)
					cpu_pkg::KIND_LOAD_A, cpu_pkg::KIND_ALU_A: begin
						acc_we_o = rdy_i;
						status_update_o = rdy_i;
					end
					cpu_pkg::KIND_LOAD_X, cpu_pkg::KIND_XFER_AX, cpu_pkg::KIND_INC_X: begin
						x_we_o = rdy_i;
						status_update_o = rdy_i;
					end
					cpu_pkg::KIND_FLAG_SET: begin
						status_update_o = rdy_i;
						set_carry_o = rdy_i;
					end
					cpu_pkg::KIND_FLAG_CLR: begin
						status_update_o = rdy_i;
						clr_carry_o = rdy_i;
					end
					default: begin
					end
				endcase
			end
			cpu_pkg::ST_OPERAND_LO: begin
				state_d = cpu_pkg::ST_FETCH;
				case (mode_i)
					cpu_pkg::MODE_IMMEDIATE: begin
						pc_inc_o = rdy_i;
						dl_we_o = rdy_i;
					end
					cpu_pkg::MODE_ABSOLUTE: begin
						pc_inc_o = rdy_i;
						adl_we_o = rdy_i;
						state_d = cpu_pkg::ST_OPERAND_HI;
					end
					cpu_pkg::MODE_RELATIVE: begin
						pc_inc_o = rdy_i;
						dl_we_o = rdy_i;
						if (zero_flag_i) begin
							state_d = cpu_pkg::ST_EXECUTE;
						end
					end
					default: begin
						// Implied, dummy read without advancing
					end
				endcase
			end
			cpu_pkg::ST_OPERAND_HI: begin
				pc_inc_o = rdy_i;
				if (kind_i == cpu_pkg::KIND_JUMP) begin
					pc_load_o = rdy_i;
					state_d = cpu_pkg::ST_FETCH;
				end else begin
					adh_we_o = rdy_i;
					state_d = cpu_pkg::ST_WRITE;
				end
			end
			cpu_pkg::ST_EXECUTE: begin
				pc_branch_o = rdy_i;
				state_d = cpu_pkg::ST_FETCH;
			end
			cpu_pkg::ST_WRITE: begin
				state_d = cpu_pkg::ST_FETCH;
			end
			default: begin
				state_d = cpu_pkg::ST_FETCH;
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_o <= cpu_pkg::ST_FETCH;
		end else if (rdy_i) begin
			state_o <= state_d;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/idec.sv ====
`timescale 1ns/1ps
`default_nettype none

module idec (
	input  logic [7:0]           opcode_i,
	output cpu_pkg::op_kind_e    kind_o,
	output cpu_pkg::mode_e       mode_o,
	output cpu_pkg::alu_func_e   alu_func_o,
	output logic [7:0]           flag_mask_o,
	output logic                 use_x_o
);

	logic [7:0] mask_nz;
	logic [7:0] mask_nvzc;

	always_comb begin
		mask_nz = 8'h00;
		mask_nz[cpu_pkg::STATUS_N] = 1'b1;
		mask_nz[cpu_pkg::STATUS_Z] = 1'b1;
		mask_nvzc = mask_nz;
		mask_nvzc[cpu_pkg::STATUS_V] = 1'b1;
		mask_nvzc[cpu_pkg::STATUS_C] = 1'b1;
	end

	always_comb begin
		kind_o = cpu_pkg::KIND_NONE;
		mode_o = cpu_pkg::MODE_IMPLIED;
		alu_func_o = cpu_pkg::ALU_PASS_B;
		flag_mask_o = 8'h00;
		use_x_o = 1'b0;
		case (opcode_i)
			cpu_pkg::OP_LDA_IMM: begin
				kind_o = cpu_pkg::KIND_LOAD_A;
				mode_o = cpu_pkg::MODE_IMMEDIATE;
				flag_mask_o = mask_nz;
			end
			cpu_pkg::OP_LDX_IMM: begin
				kind_o = cpu_pkg::KIND_LOAD_X;
				mode_o = cpu_pkg::MODE_IMMEDIATE;
				flag_mask_o = mask_nz;
			end
			cpu_pkg::OP_ADC_IMM: begin
				kind_o = cpu_pkg::KIND_ALU_A;
				mode_o = cpu_pkg::MODE_IMMEDIATE;
				alu_func_o = cpu_pkg::ALU_ADC;
				flag_mask_o = mask_nvzc;
			end
			cpu_pkg::OP_AND_IMM: begin
				kind_o = cpu_pkg::KIND_ALU_A;
				mode_o = cpu_pkg::MODE_IMMEDIATE;
				alu_func_o = cpu_pkg::ALU_AND;
				flag_mask_o = mask_nz;
			end
			cpu_pkg::OP_EOR_IMM: begin
				kind_o = cpu_pkg::KIND_ALU_A;
				mode_o = cpu_pkg::MODE_IMMEDIATE;
				alu_func_o = cpu_pkg::ALU_EOR;
				flag_mask_o = mask_nz;
			end
			cpu_pkg::OP_STA_ABS: begin
				kind_o = cpu_pkg::KIND_STORE_A;
				mode_o = cpu_pkg::MODE_ABSOLUTE;
			end
			cpu_pkg::OP_INX: begin
				kind_o = cpu_pkg::KIND_INC_X;
				alu_func_o = cpu_pkg::ALU_INC_A;
				flag_mask_o = mask_nz;
				use_x_o = 1'b1;
			end
			cpu_pkg::OP_TAX: begin
				// A xor zero, B is forced to zero in implied mode
				kind_o = cpu_pkg::KIND_XFER_AX;
				alu_func_o = cpu_pkg::ALU_EOR;
				flag_mask_o = mask_nz;
			end
			cpu_pkg::OP_CLC: begin
				kind_o = cpu_pkg::KIND_FLAG_CLR;
			end
			cpu_pkg::OP_SEC: begin
				kind_o = cpu_pkg::KIND_FLAG_SET;
			end
			cpu_pkg::OP_JMP_ABS: begin
				kind_o = cpu_pkg::KIND_JUMP;
				mode_o = cpu_pkg::MODE_ABSOLUTE;
			end
			cpu_pkg::OP_BEQ: begin
				// Taken when Z is set
				kind_o = cpu_pkg::KIND_BRANCH;
				mode_o = cpu_pkg::MODE_RELATIVE;
				use_x_o = 1'b1;
			end
			cpu_pkg::OP_BNE: begin
				kind_o = cpu_pkg::KIND_BRANCH;
				mode_o = cpu_pkg::MODE_RELATIVE;
			end
			default: begin
				// NOP and any undecoded byte
				kind_o = cpu_pkg::KIND_NONE;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/pc.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc (
	input  logic        clk_i,
	input  logic        reset_i,
	input  logic        inc_i,
	input  logic        load_i,
	input  logic        branch_i,
	input  logic [15:0] target_i,
	input  logic [7:0]  offset_i,
	output logic [15:0] pc_o
);

	logic [15:0] offset_ext;

	assign offset_ext = {{8{offset_i[7]}}, offset_i};

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pc_o <= cpu_pkg::RESET_PC;
		end else if (load_i) begin
			pc_o <= target_i;
		end else if (branch_i) begin
			pc_o <= pc_o + offset_ext;
		end else if (inc_i) begin
			pc_o <= pc_o + 16'd1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/status_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module status_reg (
	input  logic       clk_i,
	input  logic       reset_i,
	input  logic       update_i,
	input  logic [7:0] flag_mask_i,
	input  logic       carry_i,
	input  logic       zero_i,
	input  logic       sign_i,
	input  logic       overflow_i,
	input  logic       set_carry_i,
	input  logic       clr_carry_i,
	output logic [7:0] status_o
);

	logic [7:0] flags;
	logic [7:0] status_d;

	always_comb begin
		flags = 8'h00;
		flags[cpu_pkg::STATUS_C] = carry_i;
		flags[cpu_pkg::STATUS_Z] = zero_i;
		flags[cpu_pkg::STATUS_V] = overflow_i;
		flags[cpu_pkg::STATUS_N] = sign_i;
		status_d = (status_o & ~flag_mask_i) | (flags & flag_mask_i);
		if (set_carry_i) begin
			status_d[cpu_pkg::STATUS_C] = 1'b1;
		end
		if (clr_carry_i) begin
			status_d[cpu_pkg::STATUS_C] = 1'b0;
		end
		// Fixed bits
		status_d[5] = cpu_pkg::STATUS_RESET[5];
		status_d[2] = cpu_pkg::STATUS_RESET[2];
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			status_o <= cpu_pkg::STATUS_RESET;
		end else if (update_i) begin
			status_o <= status_d;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  cpu_pkg::alu_func_e alu_func_i,
	input  logic [7:0]         a_i,
	input  logic [7:0]         b_i,
	input  logic               carry_i,
	output logic [7:0]         result_o,
	output logic               carry_o,
	output logic               zero_o,
	output logic               sign_o,
	output logic               overflow_o
);

	logic [8:0] sum;

	always_comb begin
		sum = {1'b0, a_i} + {1'b0, b_i} + {8'd0, carry_i};
		carry_o = carry_i;
		result_o = b_i;
		case (alu_func_i)
			cpu_pkg::ALU_PASS_B: begin
				result_o = b_i;
			end
			cpu_pkg::ALU_ADC: begin
				result_o = sum[7:0];
				carry_o = sum[8];
			end
			cpu_pkg::ALU_AND: begin
				result_o = a_i & b_i;
			end
			cpu_pkg::ALU_EOR: begin
				result_o = a_i ^ b_i;
			end
			cpu_pkg::ALU_INC_A: begin
				result_o = a_i + 8'd1;
			end
			default: begin
				result_o = b_i;
			end
		endcase
	end

	// Operands agree in sign but the sum does not
	assign overflow_o = (a_i[7] == b_i[7]) && (sum[7] != a_i[7]);

	assign zero_o = (result_o == 8'h00);
	assign sign_o = result_o[7];

endmodule

`default_nettype wire

// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// Supported opcode bytes, 6502 encodings
	typedef enum logic [7:0] {
		OP_LDA_IMM = 8'hA9,
		OP_LDX_IMM = 8'hA2,
		OP_ADC_IMM = 8'h69,
		OP_AND_IMM = 8'h29,
		OP_EOR_IMM = 8'h49,
		OP_STA_ABS = 8'h8D,
		OP_INX     = 8'hE8,
		OP_TAX     = 8'hAA,
		OP_CLC     = 8'h18,
		OP_SEC     = 8'h38,
		OP_JMP_ABS = 8'h4C,
		OP_BEQ     = 8'hF0,
		OP_BNE     = 8'hD0,
		OP_NOP     = 8'hEA
	} opcode_e;

	typedef enum logic [1:0] {
		MODE_IMPLIED,
		MODE_IMMEDIATE,
		MODE_ABSOLUTE,
		MODE_RELATIVE
	} mode_e;

	typedef enum logic [2:0] {
		ALU_PASS_B,
		ALU_ADC,
		ALU_AND,
		ALU_EOR,
		ALU_INC_A
	} alu_func_e;

	typedef enum logic [3:0] {
		KIND_LOAD_A,
		KIND_LOAD_X,
		KIND_ALU_A,
		KIND_STORE_A,
		KIND_XFER_AX,
		KIND_INC_X,
		KIND_FLAG_SET,
		KIND_FLAG_CLR,
		KIND_JUMP,
		KIND_BRANCH,
		KIND_NONE
	} op_kind_e;

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_OPERAND_LO,
		ST_OPERAND_HI,
		ST_EXECUTE,
		ST_WRITE
	} seq_state_e;

	// Flag bit positions in the status register
	localparam logic [2:0] STATUS_C = 3'd0;
	localparam logic [2:0] STATUS_Z = 3'd1;
	localparam logic [2:0] STATUS_V = 3'd6;
	localparam logic [2:0] STATUS_N = 3'd7;

	localparam logic [15:0] RESET_PC = 16'h0200;
	localparam logic [7:0] STATUS_RESET = 8'h24;

endpackage

`default_nettype wire
